// File: dv/busNetTb.sv
`timescale 1ns/100ps
`include "busNet_macros.svh"

module busNetTb;
	import busPkg::*;

	localparam int NumEntries = 12;
	localparam int ResetCycles = 4;
	localparam int ClockPeriod = 40;
	// 120 cycles per station per entry, plus reset and the idle check
	localparam int WatchdogCycles = NumEntries * `NUM_STATIONS * 120 + ResetCycles + 16;

	logic clock;
	logic rst;
	logic [`NUM_STATIONS-1:0] mod;
	logic [`NUM_STATIONS-1:0][`DATA_WIDTH-1:0] stationData;
	stationIdT [`NUM_STATIONS-1:0] stationDst;
	crcT [`NUM_STATIONS-1:0] stationCrc;
	logic busShow;
	logic rxValid;
	stationIdT rxSrc;
	stationIdT rxDst;
	logic [`DATA_WIDTH-1:0] rxData;
	logic [7:0] crcErrCount;

	// Stimulus table
	logic [`NUM_STATIONS-1:0] reqTbl [NumEntries];
	logic [`NUM_STATIONS-1:0] lateTbl [NumEntries];
	logic [`NUM_STATIONS-1:0] badTbl [NumEntries];
	logic rndTbl [NumEntries];
	logic [31:0] seedTbl [NumEntries];
	logic [3:0] dstOffTbl [NumEntries];

	// Station values of the current entry
	logic [`DATA_WIDTH-1:0] stData [`NUM_STATIONS];
	logic [3:0] stDst [`NUM_STATIONS];
	logic [3:0] stCrc [`NUM_STATIONS];

	// Expected {src, dst, data}, in delivery order
	logic [71:0] expQ [$];
	logic [71:0] expFrame;
	logic [7:0] expErr;
	int lastPtr;

	busNetTop DUT (
		.clock(clock),
		.rst(rst),
		.mod(mod),
		.stationData(stationData),
		.stationDst(stationDst),
		.stationCrc(stationCrc),
		.busShow(busShow),
		.rxValid(rxValid),
		.rxSrc(rxSrc),
		.rxDst(rxDst),
		.rxData(rxData),
		.crcErrCount(crcErrCount)
	);

	always #(ClockPeriod / 2) clock = ~clock;

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// Bit-serial CRC-4, x^4+x+1, init 0, dst then data MSB first
	function automatic logic [3:0] crcRef(input logic [3:0] dst, input logic [63:0] data);
		logic [67:0] bits;
		logic [3:0] c;
		logic fb;
		bits = {dst, data};
		c = 4'h0;
		for (int i = 67; i >= 0; i--) begin
			fb = c[3] ^ bits[i];
			c = {c[2:0], 1'b0};
			if (fb)
				c = c ^ `CRC_POLY;
		end
		return c;
	endfunction

	task automatic expectStation(input int s, input int e);
		if (badTbl[e][s])
			expErr = expErr + 8'd1;
		else
			expQ.push_back({4'(s), stDst[s], stData[s]});
	endtask

	// First grant comes from the entry mask, late bits join the cycle behind it
	task automatic predictEntry(input int e);
		logic [`NUM_STATIONS-1:0] all;
		int first;
		int s;
		first = -1;
		all = reqTbl[e] | lateTbl[e];
		for (int i = 1; i <= `NUM_STATIONS; i++) begin
			s = (lastPtr + i) % `NUM_STATIONS;
			if (first < 0 && reqTbl[e][s])
				first = s;
		end
		expectStation(first, e);
		lastPtr = first;
		for (int i = 1; i < `NUM_STATIONS; i++) begin
			s = (first + i) % `NUM_STATIONS;
			if (all[s]) begin
				expectStation(s, e);
				lastPtr = s;
			end
		end
	endtask

	task automatic setEntry(input int e, input logic [15:0] req, input logic [15:0] late,
		input logic [15:0] bad, input logic rnd, input logic [31:0] seed, input logic [3:0] off);
		reqTbl[e] = req;
		lateTbl[e] = late;
		badTbl[e] = bad;
		rndTbl[e] = rnd;
		seedTbl[e] = seed;
		dstOffTbl[e] = off;
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic applyEntry(input int e);
		logic [`DATA_WIDTH-1:0] d;
		logic [3:0] dst;
		for (int s = 0; s < `NUM_STATIONS; s++) begin
			if (rndTbl[e])
				d = {$urandom, $urandom};
			else
				d = {seedTbl[e] + 32'(s), ~seedTbl[e] ^ (32'(s) * 32'h01010101)};
			dst = 4'(s) + dstOffTbl[e];
			stData[s] = d;
			stDst[s] = dst;
			stCrc[s] = crcRef(dst, d) ^ (badTbl[e][s] ? 4'h9 : 4'h0);
		end
		predictEntry(e);
		@(posedge clock);
		for (int s = 0; s < `NUM_STATIONS; s++) begin
			stationData[s] <= stData[s];
			stationDst[s] <= stDst[s];
			stationCrc[s] <= stCrc[s];
		end
		mod <= reqTbl[e];
		@(posedge clock);
		mod <= '0;
		// Late requests land while the first frame is in the checker
		if (lateTbl[e] != '0) begin
			repeat (3) @(posedge clock);
			mod <= lateTbl[e];
			@(posedge clock);
			mod <= '0;
		end
	endtask

	task automatic waitEntryDone();
		while (expQ.size() != 0 || crcErrCount < expErr)
			@(posedge clock);
		repeat (4) @(negedge clock);
		assert (crcErrCount == expErr)
		else stopWithFailure($sformatf("ERR crcErrCount 0x%h expected 0x%h",
			crcErrCount, expErr));
		@(posedge clock);
	endtask

	// Scoreboard, sampled away from the active edge
	always @(negedge clock) begin
		if (!rst && rxValid) begin
			assert (expQ.size() != 0)
			else stopWithFailure("A frame was delivered on the bus when none was expected");
			expFrame = expQ.pop_front();
			assert (rxSrc == expFrame[71:68])
			else stopWithFailure($sformatf("ERR rxSrc 0x%h expected 0x%h",
				rxSrc, expFrame[71:68]));
			assert (rxDst == expFrame[67:64])
			else stopWithFailure($sformatf("ERR rxDst 0x%h expected 0x%h",
				rxDst, expFrame[67:64]));
			assert (rxData == expFrame[63:0])
			else stopWithFailure($sformatf("ERR rxData 0x%h expected 0x%h",
				rxData, expFrame[63:0]));
		end
	end

	initial begin
		#(WatchdogCycles * ClockPeriod);
		stopWithFailure("The run hung, frames stopped arriving before the watchdog limit");
	end

	initial begin
		void'($urandom(91));
		clock = 1'b0;
		rst = 1'b1;
		mod = '0;
		stationData = '0;
		stationDst = '0;
		stationCrc = '0;
		expErr = 8'd0;
		lastPtr = `NUM_STATIONS - 1;

		// req, late, bad, random, seed, dst offset
		setEntry(0, 16'h0001, 16'h0000, 16'h0000, 1'b0, 32'h1000_0000, 4'h3);
		setEntry(1, 16'h0020, 16'h0000, 16'h0000, 1'b0, 32'h2345_6789, 4'h7);
		setEntry(2, 16'h0013, 16'h0000, 16'h0000, 1'b0, 32'hCAFE_0000, 4'h1);
		setEntry(3, 16'h8000, 16'h0000, 16'h8000, 1'b0, 32'h0BAD_0BAD, 4'h2);
		setEntry(4, 16'h0F00, 16'h0000, 16'h0200, 1'b1, 32'h0, 4'h5);
		setEntry(5, 16'h0001, 16'h5000, 16'h0000, 1'b0, 32'h5555_AAAA, 4'h9);
		setEntry(6, 16'hFFFF, 16'h0000, 16'h0101, 1'b1, 32'h0, 4'hC);
		setEntry(7, 16'h0010, 16'h0008, 16'h0000, 1'b0, 32'h7777_0001, 4'h4);
		setEntry(8, 16'h0600, 16'h0000, 16'h0600, 1'b0, 32'h8888_8888, 4'h6);
		setEntry(9, 16'h00C0, 16'h0300, 16'h0100, 1'b1, 32'h0, 4'hA);
		setEntry(10, 16'h1000, 16'h0800, 16'h0000, 1'b1, 32'h0, 4'hE);
		setEntry(11, 16'h2222, 16'h0000, 16'h0002, 1'b0, 32'hFEED_BEEF, 4'hB);

		repeat (ResetCycles) @(posedge clock);
		rst <= 1'b0;

		// Quiet bus before the first request
		repeat (8) begin
			@(negedge clock);
			assert (busShow == 1'b0)
			else stopWithFailure($sformatf("ERR busShow 0x%h expected 0x0", busShow));
			assert (rxValid == 1'b0)
			else stopWithFailure($sformatf("ERR rxValid 0x%h expected 0x0", rxValid));
			assert (crcErrCount == 8'd0)
			else stopWithFailure($sformatf("ERR crcErrCount 0x%h expected 0x0", crcErrCount));
		end

		for (int e = 0; e < NumEntries; e++) begin
			applyEntry(e);
			waitEntryDone();
		end

		$display("All checks passed");
		$finish;
	end

endmodule

// File: include/busNet_macros.svh
`ifndef BUSNET_MACROS_SVH
`define BUSNET_MACROS_SVH

// Stations sharing the bus
`define NUM_STATIONS 16

// Payload word carried by each frame
`define DATA_WIDTH 64

// CRC-4 over dst and data, MSB first, init 0
`define CRC_WIDTH 4

// x^4 + x + 1 with the top term implied
`define CRC_POLY 4'h3

// src 4 + dst 4 + data 64 + crc 4
`define FRAME_BITS 76

`endif

// File: src.f
+incdir+include
src/busPkg.sv
src/frameIf.sv
src/busArbiter.sv
src/crcChecker.sv
src/frameSerializer.sv
src/busReceiver.sv
src/busNetTop.sv
dv/busNetTb.sv

// File: src/busArbiter.sv
`timescale 1ns/100ps
`include "busNet_macros.svh"

module busArbiter (
	input  logic clock,
	input  logic rst,
	input  logic [`NUM_STATIONS-1:0] mod,
	input  logic [`NUM_STATIONS-1:0][`DATA_WIDTH-1:0] stationData,
	input  busPkg::stationIdT [`NUM_STATIONS-1:0] stationDst,
	input  busPkg::crcT [`NUM_STATIONS-1:0] stationCrc,
	frameIf.source grantOut
);
	import busPkg::*;

	logic [`NUM_STATIONS-1:0] pending;
	logic [`NUM_STATIONS-1:0] grantMask;
	stationIdT lastGrant;
	stationIdT nextId;
	stationIdT cand;
	logic found;
	logic grantEn;

	////////////////////////////////////////
	// Round-robin search
	////////////////////////////////////////

	// Starts one past the last granted station and wraps
	always_comb begin
		found = 1'b0;
		nextId = lastGrant;
		cand = lastGrant;
		for (int i = 1; i <= `NUM_STATIONS; i++) begin
			cand = stationIdT'(lastGrant + i);
			if (!found && pending[cand]) begin
				found = 1'b1;
				nextId = cand;
			end
		end
	end

	// No grant while the strobe is still out, the sink only raises busy next cycle
	assign grantEn = found && !grantOut.busy && !grantOut.valid;

	always_comb begin
		grantMask = '0;
		if (grantEn)
			grantMask[nextId] = 1'b1;
	end

	////////////////////////////////////////
	// Pending bits, pointer and strobe
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			pending <= '0;
			// Station 0 comes first after reset
			lastGrant <= stationIdT'(`NUM_STATIONS - 1);
			grantOut.valid <= 1'b0;
		end else begin
			// A new request wins over the clear of the same bit
			pending <= (pending & ~grantMask) | mod;
			grantOut.valid <= grantEn;
			if (grantEn)
				lastGrant <= nextId;
		end
	end

	// Frame sampled from the granted station
	always_ff @(posedge clock) begin
		if (grantEn) begin
			grantOut.frame.src <= nextId;
			grantOut.frame.dst <= stationDst[nextId];
			grantOut.frame.data <= stationData[nextId];
			grantOut.frame.crc <= stationCrc[nextId];
		end
	end

	// Checker must never see a strobe while it is still working
	validOnlyWhenFree: assert property (@(posedge clock) disable iff (rst)
		$rose(grantOut.valid) |-> !grantOut.busy);

endmodule

// File: src/busNetTop.sv
`timescale 1ns/100ps
`include "busNet_macros.svh"

module busNetTop (
	input  logic clock,
	input  logic rst,
	input  logic [`NUM_STATIONS-1:0] mod,
	input  logic [`NUM_STATIONS-1:0][`DATA_WIDTH-1:0] stationData,
	input  busPkg::stationIdT [`NUM_STATIONS-1:0] stationDst,
	input  busPkg::crcT [`NUM_STATIONS-1:0] stationCrc,
	output logic busShow,
	output logic rxValid,
	output busPkg::stationIdT rxSrc,
	output busPkg::stationIdT rxDst,
	output logic [`DATA_WIDTH-1:0] rxData,
	output logic [7:0] crcErrCount
);

	////////////////////////////////////////
	// Internal frame links
	////////////////////////////////////////

	// Arbiter to checker
	frameIf grantIf ();
	// Checker to serializer
	frameIf checkedIf ();

	busArbiter arbiter (
		.clock(clock),
		.rst(rst),
		.mod(mod),
		.stationData(stationData),
		.stationDst(stationDst),
		.stationCrc(stationCrc),
		.grantOut(grantIf.source)
	);

	crcChecker crcCheck (
		.clock(clock),
		.rst(rst),
		.frameIn(grantIf.sink),
		.frameOut(checkedIf.source),
		.crcErrCount(crcErrCount)
	);

	////////////////////////////////////////
	// Serial bus and listening station
	////////////////////////////////////////

	frameSerializer serializer (
		.clock(clock),
		.rst(rst),
		.frameIn(checkedIf.sink),
		.busShow(busShow)
	);

	busReceiver receiver (
		.clock(clock),
		.rst(rst),
		.busShow(busShow),
		.rxValid(rxValid),
		.rxSrc(rxSrc),
		.rxDst(rxDst),
		.rxData(rxData)
	);

endmodule

// File: src/busPkg.sv
`include "busNet_macros.svh"

package busPkg;

	////////////////////////////////////////
	// Station numbering
	////////////////////////////////////////

	typedef logic [3:0] stationIdT;

	////////////////////////////////////////
	// CRC and frame layout
	////////////////////////////////////////

	typedef logic [`CRC_WIDTH-1:0] crcT;

	// Field order matches the order on the wire
	typedef struct packed {
		stationIdT src;
		stationIdT dst;
		logic [`DATA_WIDTH-1:0] data;
		crcT crc;
	} frameT;

endpackage

// File: src/busReceiver.sv
`timescale 1ns/100ps
`include "busNet_macros.svh"

module busReceiver (
	input  logic clock,
	input  logic rst,
	input  logic busShow,
	output logic rxValid,
	output busPkg::stationIdT rxSrc,
	output busPkg::stationIdT rxDst,
	output logic [`DATA_WIDTH-1:0] rxData
);
	import busPkg::*;

	logic receiving;
	logic [6:0] bitCnt;
	logic [`FRAME_BITS-1:0] shiftReg;
	frameT rxFrame;

	// Fields hold after the last bit until the next frame
	assign rxFrame = frameT'(shiftReg);
	assign rxSrc = rxFrame.src;
	assign rxDst = rxFrame.dst;
	assign rxData = rxFrame.data;

	////////////////////////////////////////
	// Start detect and bit collection
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			receiving <= 1'b0;
			bitCnt <= '0;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			if (!receiving) begin
				if (busShow) begin
					receiving <= 1'b1;
					bitCnt <= '0;
				end
			end else begin
				bitCnt <= bitCnt + 7'd1;
				if (bitCnt == 7'(`FRAME_BITS - 1)) begin
					receiving <= 1'b0;
					rxValid <= 1'b1;
				end
			end
		end
	end

	// Frame bits in arrival order
	always_ff @(posedge clock) begin
		if (receiving)
			shiftReg <= {shiftReg[`FRAME_BITS-2:0], busShow};
	end

	// Line back at 0 after the last bit so the next start is seen
	noStartWhileReceiving: assert property (@(posedge clock) disable iff (rst)
		(receiving && bitCnt == 7'(`FRAME_BITS - 1)) |=> !busShow);

endmodule

// File: src/crcChecker.sv
`timescale 1ns/100ps
`include "busNet_macros.svh"

module crcChecker #(
	// Nibbles over dst and data
	parameter int NibbleCount = ($bits(busPkg::frameT) - $bits(busPkg::stationIdT)
		- $bits(busPkg::crcT)) / 4
) (
	input  logic clock,
	input  logic rst,
	frameIf.sink frameIn,
	frameIf.source frameOut,
	output logic [7:0] crcErrCount
);
	import busPkg::*;

	typedef enum logic [1:0] {
		Idle,
		Calc,
		Check
	} stateT;

	stateT state;
	frameT held;
	crcT crcAcc;
	logic [4:0] nibCnt;
	logic [4*NibbleCount-1:0] covered;
	logic [3:0] nibble;

	// Four serial LFSR steps, MSB of the nibble first
	function automatic crcT crcNibble(crcT c, logic [3:0] nib);
		crcT r;
		logic fb;
		r = c;
		for (int b = 3; b >= 0; b--) begin
			fb = r[`CRC_WIDTH-1] ^ nib[b];
			r = {r[`CRC_WIDTH-2:0], 1'b0} ^ (fb ? `CRC_POLY : '0);
		end
		return r;
	endfunction

	assign covered = {held.dst, held.data};
	assign nibble = covered[4*NibbleCount - 1 - 4*nibCnt -: 4];

	// Busy through the calculation and any wait on the serializer
	assign frameIn.busy = (state != Idle);
	assign frameOut.frame = held;

	////////////////////////////////////////
	// Check FSM
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= Idle;
			crcAcc <= '0;
			nibCnt <= '0;
			frameOut.valid <= 1'b0;
			crcErrCount <= '0;
		end else begin
			frameOut.valid <= 1'b0;
			case (state)
				Idle: begin
					if (frameIn.valid) begin
						crcAcc <= '0;
						nibCnt <= '0;
						state <= Calc;
					end
				end
				Calc: begin
					crcAcc <= crcNibble(crcAcc, nibble);
					nibCnt <= nibCnt + 5'd1;
					if (nibCnt == 5'(NibbleCount - 1))
						state <= Check;
				end
				Check: begin
					if (crcAcc != held.crc) begin
						// Dropped frame, counter sticks at the top
						if (crcErrCount != 8'hFF)
							crcErrCount <= crcErrCount + 8'd1;
						state <= Idle;
					end else if (!frameOut.busy) begin
						frameOut.valid <= 1'b1;
						state <= Idle;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == Idle && frameIn.valid)
			held <= frameIn.frame;
	end

	nibbleCountInRange: assert property (@(posedge clock) disable iff (rst)
		nibCnt <= 5'(NibbleCount));

endmodule

// File: src/frameIf.sv
`timescale 1ns/100ps

interface frameIf;
	import busPkg::*;

	// One-cycle strobe from the producer
	logic valid;
	frameT frame;
	// Level from the consumer, high from the cycle after a take
	logic busy;

	modport source (
		output valid,
		output frame,
		input  busy
	);

	modport sink (
		input  valid,
		input  frame,
		output busy
	);

endinterface

// File: src/frameSerializer.sv
`timescale 1ns/100ps
`include "busNet_macros.svh"

module frameSerializer (
	input  logic clock,
	input  logic rst,
	frameIf.sink frameIn,
	output logic busShow
);

	// Start bit on top of the frame
	logic [`FRAME_BITS:0] shiftReg;
	logic [6:0] bitCnt;
	logic take;

	assign take = frameIn.valid && !frameIn.busy;

	// High through the last frame bit
	assign frameIn.busy = (bitCnt != 7'd0);

	// Zeros shift in behind the frame, so the line drops on its own
	assign busShow = shiftReg[`FRAME_BITS];

	////////////////////////////////////////
	// Shift and count
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			shiftReg <= '0;
			bitCnt <= '0;
		end else if (take) begin
			shiftReg <= {1'b1, frameIn.frame};
			bitCnt <= 7'(`FRAME_BITS + 1);
		end else if (bitCnt != 7'd0) begin
			shiftReg <= {shiftReg[`FRAME_BITS-1:0], 1'b0};
			bitCnt <= bitCnt - 7'd1;
		end
	end

	// Nothing stays on the wire once the frame is out
	idleLineLow: assert property (@(posedge clock) disable iff (rst)
		(bitCnt == 7'd0) |-> !busShow);

endmodule
